//--- Makefile
VERILATOR = verilator
VFLAGS    = --binary --timing --timescale 1ns/100ps -j 0
LINTFLAGS = --lint-only --timing --timescale 1ns/100ps -Wall
TOP       = readCacheTb
FILELIST  = verilog.f
OBJDIR    = obj_dir
PASSMSG   = Testbench passed

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJDIR) -f $(FILELIST)

# The run fails unless the pass message appears on a line of its own
run: build
	@out="$$(./$(OBJDIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "$(PASSMSG)"

lint:
	$(VERILATOR) $(LINTFLAGS) --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(OBJDIR)

//--- rtl/cacheController.sv
`timescale 1ns/100ps
`default_nettype none

module cacheController
  import cacheGeomPkg::*;
  import cacheCtrlPkg::*;
(
  input  logic       clk,
  input  logic       reset,
  input  logic       reqValid,
  input  addrT       reqAddr,
  output logic       ready,
  output logic       respValid,
  output logic       respHit,
  output wordT       respData,
  output logic       memReq,
  output lineAddrT   memLineAddr,
  input  logic       memValid,
  output logic       lookupEn,
  output setIndexT   lookupIndex,
  output tagT        lookupTag,
  output wordOffsetT reqOffset,
  output logic       fillEn,
  output wayMaskT    fillWay,
  output tagT        fillTag,
  output wordOffsetT fillOffset,
  output logic       plruUpdate,
  output wayMaskT    accessWay,
  input  wayMaskT    wayHit,
  input  wayMaskT    victimWay,
  input  wordT       readWord
);

  cacheStateT state;
  cacheStateT stateNext;

  // The request being served and whether it had to be refilled
  addrT      reqAddrQ;
  logic      missed;
  fillCountT fillCount;

  logic lineHit;
  logic lastStrobe;

  assign lineHit    = |wayHit;
  assign lastStrobe = memValid && (fillCount == fillCountT'(wordsPerLine - 1));

  // Fields of the latched address feed the arrays for the whole request
  assign lookupTag   = reqAddrQ[addrWidth-1 -: tagWidth];
  assign lookupIndex = reqAddrQ[offsetWidth +: indexWidth];
  assign reqOffset   = reqAddrQ[offsetWidth-1:0];
  assign memLineAddr = reqAddrQ[addrWidth-1:offsetWidth];
  assign fillTag     = lookupTag;
  assign fillOffset  = fillCount;

  ////////////////////
  // State machine
  ////////////////////

  always_comb begin
    stateNext = state;
    case (state)
      idleS: begin
        if (reqValid) begin
          stateNext = lookupS;
        end
      end
      lookupS:   stateNext = compareS;
      compareS:  stateNext = lineHit ? respondS : fillWaitS;
      // Memory strobes may come with gaps, so wait for all four
      fillWaitS: begin
        if (lastStrobe) begin
          stateNext = fillS;
        end
      end
      // Line complete, the last word is in place before the reread
      fillS:     stateNext = replayS;
      replayS:   stateNext = compareS;
      respondS:  stateNext = idleS;
      default:   stateNext = idleS;
    endcase
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      state     <= idleS;
      missed    <= 1'b0;
      fillCount <= '0;
    end else begin
      state <= stateNext;
      // The miss flag lives from acceptance to the replayed hit
      if (ready && reqValid) begin
        missed <= 1'b0;
      end else if (memReq) begin
        missed <= 1'b1;
      end
      if (memReq) begin
        fillCount <= '0;
      end else if (fillEn) begin
        fillCount <= fillCount + 1'b1;
      end
    end
  end

  ////////////////////
  // Request and response
  ////////////////////

  // Victim is taken from the same tree read as the failed compare
  always_ff @(posedge clk) begin
    if (ready && reqValid) begin
      reqAddrQ <= reqAddr;
    end
    if (memReq) begin
      fillWay <= victimWay;
    end
    if ((state == compareS) && lineHit) begin
      respData <= readWord;
      respHit  <= ~missed;
    end
  end

  // New requests only enter while idle
  assign ready     = (state == idleS);
  assign lookupEn  = (state == lookupS) || (state == replayS);
  assign memReq    = (state == compareS) && !lineHit;
  assign fillEn    = (state == fillWaitS) && memValid;
  assign respValid = (state == respondS);

  // One replacement update per request, at the compare that hits
  // After a miss this is the replay, so the refilled way is marked used
  assign plruUpdate = (state == compareS) && lineHit;
  assign accessWay  = wayHit;

endmodule

`default_nettype wire

//--- rtl/cacheCtrlPkg.sv
`default_nettype none

// Types private to the cache controller
package cacheCtrlPkg;

  // States of the controller, one request at a time
  typedef enum logic [2:0] {
    idleS,
    lookupS,
    compareS,
    fillWaitS,
    fillS,
    replayS,
    respondS
  } cacheStateT;

  // Counts the memory strobes of one line fill
  localparam int fillCountWidth = 2;
  typedef logic [fillCountWidth-1:0] fillCountT;

endpackage

`default_nettype wire

//--- rtl/cacheGeomPkg.sv
`default_nettype none

// Geometry of the read cache and the vector types that name its fields
package cacheGeomPkg;

  ////////////////////
  // Sizes
  ////////////////////

  localparam int numWays      = 4;
  localparam int numSets      = 16;
  localparam int wordsPerLine = 4;

  // Widths of the word address fields, tag above index above offset
  localparam int addrWidth   = 16;
  localparam int offsetWidth = 2;
  localparam int indexWidth  = 4;
  localparam int tagWidth    = addrWidth - indexWidth - offsetWidth;
  localparam int dataWidth   = 32;

  ////////////////////
  // Field types
  ////////////////////

  typedef logic [addrWidth-1:0]   addrT;
  typedef logic [tagWidth-1:0]    tagT;
  typedef logic [indexWidth-1:0]  setIndexT;
  typedef logic [offsetWidth-1:0] wordOffsetT;
  typedef logic [dataWidth-1:0]   wordT;

  // One bit per way, at most one set at a time
  typedef logic [numWays-1:0] wayMaskT;
  // Tree pseudo-LRU needs one bit per internal node
  typedef logic [numWays-2:0] plruBitsT;
  // Line address sent to the backing memory, tag and index together
  typedef logic [tagWidth+indexWidth-1:0] lineAddrT;

endpackage

`default_nettype wire

//--- rtl/dataArray.sv
`timescale 1ns/100ps
`default_nettype none

module dataArray
  import cacheGeomPkg::*;
(
  input  logic       clk,
  input  logic       lookupEn,
  input  setIndexT   lookupIndex,
  input  wordOffsetT reqOffset,
  input  logic       fillEn,
  input  wayMaskT    fillWay,
  input  wordOffsetT fillOffset,
  input  wordT       memData,
  input  wayMaskT    wayHit,
  output wordT       readWord
);

  // Every word of every line, addressed by set, way and word offset
  wordT lineStore [numSets][numWays][wordsPerLine];

  // The requested word of each way, captured at lookup
  wordT candWords [numWays];

  ////////////////////
  // Line fill
  ////////////////////

  // One word per memory strobe lands in the victim way
  always_ff @(posedge clk) begin
    for (int w = 0; w < numWays; w++) begin
      if (fillEn && fillWay[w]) begin
        lineStore[lookupIndex][w][fillOffset] <= memData;
      end
    end
  end

  ////////////////////
  // Word read
  ////////////////////

  // All four ways are read at once, the tag compare picks one later
  always_ff @(posedge clk) begin
    if (lookupEn) begin
      for (int w = 0; w < numWays; w++) begin
        candWords[w] <= lineStore[lookupIndex][w][reqOffset];
      end
    end
  end

  // AND-OR select on the one-hot hit mask
  // With no hit the word reads as zero
  always_comb begin
    readWord = '0;
    for (int w = 0; w < numWays; w++) begin
      if (wayHit[w]) begin
        readWord = readWord | candWords[w];
      end
    end
  end

endmodule

`default_nettype wire

//--- rtl/plruReplacement.sv
`timescale 1ns/100ps
`default_nettype none

module plruReplacement
  import cacheGeomPkg::*;
(
  input  logic     clk,
  input  logic     reset,
  input  logic     lookupEn,
  input  setIndexT lookupIndex,
  input  logic     plruUpdate,
  input  wayMaskT  accessWay,
  output wayMaskT  victimWay
);

  // Tree of each set
  // Bit 2 is the root, bit 1 covers ways 2 and 3, bit 0 covers ways 0 and 1
  plruBitsT [numSets-1:0] treeBits;

  // Tree of the looked-up set and the set it came from
  plruBitsT curTree;
  setIndexT curIndex;

  // Per node, whether the access touches it and the value it then takes
  plruBitsT nodeEn;
  plruBitsT nodeMask;
  plruBitsT newTree;

  // The update is carried one edge before it is written back
  logic     updatePend;
  plruBitsT newTreeQ;

  ////////////////////
  // Tree read
  ////////////////////

  always_ff @(posedge clk) begin
    if (reset) begin
      curTree  <= '0;
      curIndex <= '0;
    end else if (lookupEn) begin
      curTree  <= treeBits[lookupIndex];
      curIndex <= lookupIndex;
    end
  end

  // Root high points at the upper pair, then the pair bit picks the way
  assign victimWay[0] = ~curTree[2] & ~curTree[0];
  assign victimWay[1] = ~curTree[2] &  curTree[0];
  assign victimWay[2] =  curTree[2] & ~curTree[1];
  assign victimWay[3] =  curTree[2] &  curTree[1];

  ////////////////////
  // Tree update
  ////////////////////

  // Any access moves the root, and only the pair node on its side moves
  assign nodeEn[2] = |accessWay;
  assign nodeEn[1] = accessWay[3] | accessWay[2];
  assign nodeEn[0] = accessWay[1] | accessWay[0];

  // Each touched node is made to point away from the accessed way
  assign nodeMask[2] = accessWay[1] | accessWay[0];
  assign nodeMask[1] = accessWay[2];
  assign nodeMask[0] = accessWay[0];

  // Untouched nodes keep their old value
  always_comb begin
    for (int n = 0; n < numWays - 1; n++) begin
      newTree[n] = nodeEn[n] ? nodeMask[n] : curTree[n];
    end
  end

  // The write-back index is the one latched with the tree
  always_ff @(posedge clk) begin
    if (reset) begin
      treeBits   <= '0;
      updatePend <= 1'b0;
    end else begin
      updatePend <= plruUpdate;
      if (updatePend) begin
        treeBits[curIndex] <= newTreeQ;
      end
    end
  end

  always_ff @(posedge clk) begin
    newTreeQ <= newTree;
  end

endmodule

`default_nettype wire

//--- rtl/readCache.sv
`timescale 1ns/100ps
`default_nettype none

module readCache
  import cacheGeomPkg::*;
(
  input  logic     clk,
  input  logic     reset,
  input  logic     reqValid,
  input  addrT     reqAddr,
  output logic     ready,
  output logic     respValid,
  output logic     respHit,
  output wordT     respData,
  output logic     memReq,
  output lineAddrT memLineAddr,
  input  logic     memValid,
  input  wordT     memData
);

  // Lookup of the current request
  logic       lookupEn;
  setIndexT   lookupIndex;
  tagT        lookupTag;
  wordOffsetT reqOffset;

  // Line fill into the victim way
  logic       fillEn;
  wayMaskT    fillWay;
  tagT        fillTag;
  wordOffsetT fillOffset;

  // Replacement bookkeeping
  logic    plruUpdate;
  wayMaskT accessWay;
  wayMaskT victimWay;

  // Lookup results
  wayMaskT wayHit;
  wordT    readWord;

  ////////////////////
  // Storage
  ////////////////////

  tagArray tags (
    .clk, .reset, .lookupEn, .lookupIndex, .lookupTag,
    .fillEn, .fillWay, .fillTag, .wayHit
  );

  dataArray data (
    .clk, .lookupEn, .lookupIndex, .reqOffset,
    .fillEn, .fillWay, .fillOffset, .memData, .wayHit, .readWord
  );

  plruReplacement plru (
    .clk, .reset, .lookupEn, .lookupIndex, .plruUpdate, .accessWay, .victimWay
  );

  ////////////////////
  // Control
  ////////////////////

  cacheController ctrl (
    .clk, .reset, .reqValid, .reqAddr, .ready, .respValid, .respHit, .respData,
    .memReq, .memLineAddr, .memValid,
    .lookupEn, .lookupIndex, .lookupTag, .reqOffset,
    .fillEn, .fillWay, .fillTag, .fillOffset,
    .plruUpdate, .accessWay, .wayHit, .victimWay, .readWord
  );

endmodule

`default_nettype wire

//--- rtl/tagArray.sv
`timescale 1ns/100ps
`default_nettype none

module tagArray
  import cacheGeomPkg::*;
(
  input  logic     clk,
  input  logic     reset,
  input  logic     lookupEn,
  input  setIndexT lookupIndex,
  input  tagT      lookupTag,
  input  logic     fillEn,
  input  wayMaskT  fillWay,
  input  tagT      fillTag,
  output wayMaskT  wayHit
);

  // Valid bits are control state and start cleared
  wayMaskT [numSets-1:0] validBits;
  // Tag storage, meaningless until the matching valid bit is set
  tagT tagStore [numSets][numWays];

  // Row of the set under lookup, held until the next lookup
  wayMaskT rowValid;
  tagT     rowTags [numWays];
  tagT     reqTagQ;

  ////////////////////
  // Fill side
  ////////////////////

  // A fill marks the chosen way valid in the set of the current request
  always_ff @(posedge clk) begin
    if (reset) begin
      validBits <= '0;
    end else if (fillEn) begin
      validBits[lookupIndex] <= validBits[lookupIndex] | fillWay;
    end
  end

  // The new tag goes only into the way the victim mask selects
  always_ff @(posedge clk) begin
    for (int w = 0; w < numWays; w++) begin
      if (fillEn && fillWay[w]) begin
        tagStore[lookupIndex][w] <= fillTag;
      end
    end
  end

  ////////////////////
  // Lookup side
  ////////////////////

  // The valid row is cleared on reset so no hit can show before a lookup
  always_ff @(posedge clk) begin
    if (reset) begin
      rowValid <= '0;
    end else if (lookupEn) begin
      rowValid <= validBits[lookupIndex];
    end
  end

  // Tags of all ways and the request tag are captured together
  always_ff @(posedge clk) begin
    if (lookupEn) begin
      reqTagQ <= lookupTag;
      for (int w = 0; w < numWays; w++) begin
        rowTags[w] <= tagStore[lookupIndex][w];
      end
    end
  end

  // All ways compare in parallel, and a tag is stored in one way at most
  always_comb begin
    for (int w = 0; w < numWays; w++) begin
      wayHit[w] = rowValid[w] && (rowTags[w] == reqTagQ);
    end
  end

endmodule

`default_nettype wire

//--- verif/readCacheChecker.sv
`timescale 1ns/100ps
`default_nettype none

module readCacheChecker
  import cacheGeomPkg::*;
(
  input  logic     clk,
  input  logic     reset,
  input  logic     reqValid,
  input  addrT     reqAddr,
  input  logic     ready,
  input  logic     respValid,
  input  logic     respHit,
  input  wordT     respData,
  input  logic     memReq,
  input  lineAddrT memLineAddr,
  output int       errorCount,
  output int       hitCount,
  output int       missCount
);

  // Which tag sits in which way, and the tree of every set
  logic     modelValid [numSets][numWays];
  tagT      modelTag   [numSets][numWays];
  plruBitsT modelTree  [numSets];

  // The request in flight and what the model expects of it
  logic busy;
  addrT curAddr;
  logic expHit;
  int   edgesSince;
  int   memReqSeen;

  ////////////////////
  // Reference model
  ////////////////////

  // Same hash as the memory model
  function automatic wordT expectedWord(input addrT addr);
    return {addr ^ 16'h3c5a, addr * 16'h9e37} ^ 32'h1234_5678;
  endfunction

  // Root picks a pair, then the pair bit picks the way
  function automatic int victimOf(input plruBitsT tree);
    if (tree[2]) begin
      return tree[1] ? 3 : 2;
    end else begin
      return tree[0] ? 1 : 0;
    end
  endfunction

  // Point the touched path away from the used way
  function automatic plruBitsT touchTree(input plruBitsT tree, input int way);
    case (way)
      0: return {1'b1, tree[1], 1'b1};
      1: return {1'b1, tree[1], 1'b0};
      2: return {1'b0, 1'b1, tree[0]};
      default: return {1'b0, 1'b0, tree[0]};
    endcase
  endfunction

  // Looks up one address and updates the model as the cache should
  task automatic modelAccess(input addrT addr, output logic hit);
    tagT      tag;
    setIndexT setIdx;
    int       way;
    tag    = addr[addrWidth-1 -: tagWidth];
    setIdx = addr[offsetWidth +: indexWidth];
    hit = 1'b0;
    way = 0;
    for (int w = 0; w < numWays; w++) begin
      if (modelValid[setIdx][w] && modelTag[setIdx][w] == tag) begin
        hit = 1'b1;
        way = w;
      end
    end
    // The PLRU way is replaced even if another way is still empty
    if (!hit) begin
      way = victimOf(modelTree[setIdx]);
      modelValid[setIdx][way] = 1'b1;
      modelTag[setIdx][way]   = tag;
    end
    modelTree[setIdx] = touchTree(modelTree[setIdx], way);
  endtask

  ////////////////////
  // Compare
  ////////////////////

  always @(posedge clk) begin
    if (reset) begin
      for (int s = 0; s < numSets; s++) begin
        modelTree[s] = '0;
        for (int w = 0; w < numWays; w++) begin
          modelValid[s][w] = 1'b0;
          modelTag[s][w]   = '0;
        end
      end
      busy       = 1'b0;
      expHit     = 1'b0;
      edgesSince = 0;
      memReqSeen = 0;
      errorCount = 0;
      hitCount   = 0;
      missCount  = 0;
    end else begin
      // Ready is high exactly when nothing is in flight
      if (ready == busy) begin
        $display("Error at %0t: ready was %b while %s", $time, ready,
          busy ? "a request was in flight" : "the cache was idle");
        errorCount++;
      end
      if (busy) begin
        edgesSince++;
      end

      if (memReq) begin
        memReqSeen++;
        if (!busy) begin
          $display("memReq pulsed at %0t with no request in flight", $time);
          errorCount++;
        end else begin
          if (memLineAddr != curAddr[addrWidth-1:offsetWidth]) begin
            $display("Error at %0t: memLineAddr %h, expected %h", $time,
              memLineAddr, curAddr[addrWidth-1:offsetWidth]);
            errorCount++;
          end
          if (expHit || edgesSince != 2 || memReqSeen != 1) begin
            $display("Error at %0t: memReq %0d after %0d cycles for %h, model hit %b",
              $time, memReqSeen, edgesSince, curAddr, expHit);
            errorCount++;
          end
        end
      end

      if (respValid) begin
        if (!busy) begin
          $display("respValid pulsed at %0t with no request in flight", $time);
          errorCount++;
        end else begin
          if (respData != expectedWord(curAddr)) begin
            $display("Error at %0t: respData %h for %h, expected %h", $time,
              respData, curAddr, expectedWord(curAddr));
            errorCount++;
          end
          if (respHit != expHit) begin
            $display("Error at %0t: respHit %b for %h, expected %b", $time,
              respHit, curAddr, expHit);
            errorCount++;
          end
          if (expHit && edgesSince != 3) begin
            $display("Error at %0t: hit answered after %0d cycles, expected 3", $time,
              edgesSince);
            errorCount++;
          end
          if (!expHit && memReqSeen != 1) begin
            $display("The miss on %h saw %0d memory requests instead of one", curAddr,
              memReqSeen);
            errorCount++;
          end
          if (expHit) begin
            hitCount++;
          end else begin
            missCount++;
          end
        end
        busy = 1'b0;
      end

      // The model answers the access at the accepting edge
      if (ready && reqValid) begin
        busy       = 1'b1;
        curAddr    = reqAddr;
        edgesSince = 0;
        memReqSeen = 0;
        modelAccess(reqAddr, expHit);
      end
    end
  end

endmodule

`default_nettype wire

//--- verif/readCacheTb.sv
`timescale 1ns/100ps
`default_nettype none

module readCacheTb
  import cacheGeomPkg::*;
();

  localparam logic [31:0] lfsrSeed = 32'h5580_c133;
  localparam int numRequests = 400;
  // Cycles from memReq to the first word of a line
  localparam int memLatency = 3;
  // Longest wait, in clock edges, for ready or for a response
  localparam int waitLimit = 200;

  // DUT inputs start at known values before the first edge
  logic       clk = 1'b0;
  logic       reset = 1'b1;
  logic       reqValid = 1'b0;
  addrT       reqAddr = '0;
  logic       memValid = 1'b0;
  wordT       memData = '0;

  logic       ready;
  logic       respValid;
  logic       respHit;
  wordT       respData;
  logic       memReq;
  lineAddrT   memLineAddr;

  int errorCount;
  int hitCount;
  int missCount;
  logic timedOut = 1'b0;
  logic [31:0] lfsrState = lfsrSeed;

  // Line being returned by the memory model
  logic       fillActive;
  lineAddrT   fillLine;
  wordOffsetT fillWord;
  int         fillDelay;

  always #50 clk = ~clk;

  readCache DUT (
    .clk, .reset, .reqValid, .reqAddr, .ready, .respValid, .respHit, .respData,
    .memReq, .memLineAddr, .memValid, .memData
  );

  readCacheChecker respCheck (
    .clk, .reset, .reqValid, .reqAddr, .ready, .respValid, .respHit, .respData,
    .memReq, .memLineAddr, .errorCount, .hitCount, .missCount
  );

  ////////////////////
  // Helpers
  ////////////////////

  // Backing memory contents, a fixed hash of the word address
  function automatic wordT memWord(input addrT addr);
    return {addr ^ 16'h3c5a, addr * 16'h9e37} ^ 32'h1234_5678;
  endfunction

  // Fibonacci LFSR, taps 32 22 2 1
  function automatic logic [31:0] lfsrNext(input logic [31:0] state);
    return {state[30:0], state[31] ^ state[21] ^ state[1] ^ state[0]};
  endfunction

  // Each bit taken costs one LFSR step
  task automatic drawBits(input int count, output logic [15:0] bits);
    bits = '0;
    for (int i = 0; i < count; i++) begin
      lfsrState = lfsrNext(lfsrState);
      bits = {bits[14:0], lfsrState[0]};
    end
  endtask

  // Eight tags shared by all sets, twice the ways, so sets overflow
  function automatic tagT tagFromPool(input logic [2:0] sel);
    case (sel)
      3'd0: return 10'h015;
      3'd1: return 10'h2a3;
      3'd2: return 10'h0f0;
      3'd3: return 10'h3c1;
      3'd4: return 10'h155;
      3'd5: return 10'h08e;
      3'd6: return 10'h270;
      default: return 10'h3ff;
    endcase
  endfunction

  // One read from ready to response, called at a rising edge
  task automatic doRead(input addrT addr);
    int waited;
    waited = 0;
    while (!ready && waited < waitLimit) begin
      @(posedge clk);
      waited++;
    end
    if (!ready) begin
      $display("Timed out at %0t waiting for ready", $time);
      timedOut = 1'b1;
    end else begin
      reqValid <= 1'b1;
      reqAddr  <= addr;
      @(posedge clk);
      reqValid <= 1'b0;
      waited = 0;
      while (!respValid && waited < waitLimit) begin
        @(posedge clk);
        waited++;
      end
      if (!respValid) begin
        $display("Timed out at %0t waiting for the response to %h", $time, addr);
        timedOut = 1'b1;
      end
    end
  endtask

  ////////////////////
  // Memory model
  ////////////////////

  // Answers each memReq with four words in offset order
  always @(posedge clk) begin
    if (reset) begin
      memValid   <= 1'b0;
      fillActive <= 1'b0;
      fillWord   <= '0;
      fillDelay  <= 0;
    end else begin
      memValid <= 1'b0;
      if (memReq) begin
        fillActive <= 1'b1;
        fillLine   <= memLineAddr;
        fillWord   <= '0;
        fillDelay  <= memLatency;
      end else if (fillActive) begin
        if (fillDelay > 0) begin
          fillDelay <= fillDelay - 1;
        end else begin
          memValid <= 1'b1;
          memData  <= memWord({fillLine, fillWord});
          fillWord <= fillWord + 1'b1;
          // Some lines get an idle cycle after the odd words
          fillDelay <= (fillLine[0] & fillWord[0]) ? 1 : 0;
          if (fillWord == 2'd3) begin
            fillActive <= 1'b0;
          end
        end
      end
    end
  end

  ////////////////////
  // Stimulus
  ////////////////////

  initial begin
    logic [15:0] bits;
    tagT         tag;
    setIndexT    index;
    addrT        lastAddr;
    lastAddr = '0;
    repeat (3) @(posedge clk);
    reset <= 1'b0;
    // A few quiet cycles, the cache must stay idle
    repeat (4) @(posedge clk);

    // Five tags into set 10 from empty, the fifth evicts the first
    for (int i = 0; i < 5 && !timedOut; i++) begin
      doRead({tagFromPool(3'(i)), 4'ha, 2'd0});
    end
    // Survivors first, then the evicted tag
    for (int i = 1; i <= 5 && !timedOut; i++) begin
      doRead({tagFromPool(3'(i % 5)), 4'ha, 2'd1});
    end

    for (int n = 0; n < numRequests && !timedOut; n++) begin
      drawBits(2, bits);
      if (bits[1:0] == 2'b00) begin
        // Another word of the line just read
        drawBits(2, bits);
        lastAddr[offsetWidth-1:0] = bits[1:0];
      end else begin
        drawBits(3, bits);
        tag = tagFromPool(bits[2:0]);
        drawBits(4, bits);
        index = bits[3:0];
        drawBits(2, bits);
        lastAddr = {tag, index, bits[1:0]};
      end
      doRead(lastAddr);
      drawBits(1, bits);
      if (bits[0]) begin
        @(posedge clk);
      end
    end

    repeat (4) @(posedge clk);
    $display("Responses %0d, hits %0d, misses %0d, errors %0d",
      hitCount + missCount, hitCount, missCount, errorCount);
    if (timedOut || errorCount != 0) begin
      $display("Testbench failed");
    end else begin
      $display("Testbench passed");
    end
    $finish;
  end

endmodule

`default_nettype wire

//--- verilog.f
rtl/cacheGeomPkg.sv
rtl/cacheCtrlPkg.sv
rtl/tagArray.sv
rtl/dataArray.sv
rtl/plruReplacement.sv
rtl/cacheController.sv
rtl/readCache.sv
verif/readCacheChecker.sv
verif/readCacheTb.sv
